/* exe_pipe.f */
+incdir+source
source/exe_pkg.sv
source/exe_issue_decode.sv
source/exe_alu.sv
source/exe_addr_translate.sv
source/exe_mem_request.sv
source/exe_top.sv
tests/exe_tb_assert.sv
tests/exe_tb.sv

/* source/exe_addr_translate.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module exe_addr_translate (
	input  logic [`EXE_XLEN-1:0] vaddr,
	input  logic [`EXE_PLV_W-1:0] cfg_plv,
	input  logic cfg_direct,
	input  logic [`EXE_MAT_W-1:0] cfg_datm,
	input  logic [`EXE_SEG_W-1:0] w0_vseg,
	input  logic [`EXE_SEG_W-1:0] w0_pseg,
	input  logic w0_plv0,
	input  logic w0_plv3,
	input  logic [`EXE_MAT_W-1:0] w0_mat,
	input  logic [`EXE_SEG_W-1:0] w1_vseg,
	input  logic [`EXE_SEG_W-1:0] w1_pseg,
	input  logic w1_plv0,
	input  logic w1_plv3,
	input  logic [`EXE_MAT_W-1:0] w1_mat,
	output logic [`EXE_XLEN-1:0] paddr,
	output logic mapped_miss,
	output logic uncache
);

	logic [`EXE_SEG_W-1:0] vseg;
	logic w0_hit;
	logic w1_hit;
	logic [`EXE_MAT_W-1:0] mat;

	// segment match plus privilege permission
	function automatic logic win_hit(
		input logic [`EXE_SEG_W-1:0] seg,
		input logic [`EXE_SEG_W-1:0] win_vseg,
		input logic [`EXE_PLV_W-1:0] plv,
		input logic allow0,
		input logic allow3
	);
		logic plv_ok;
		plv_ok = ((plv == `EXE_PLV0) && allow0) || ((plv == `EXE_PLV3) && allow3);
		return (seg == win_vseg) && plv_ok;
	endfunction

	assign vseg   = vaddr[`EXE_XLEN-1 -: `EXE_SEG_W];
	assign w0_hit = win_hit(vseg, w0_vseg, cfg_plv, w0_plv0, w0_plv3);
	assign w1_hit = win_hit(vseg, w1_vseg, cfg_plv, w1_plv0, w1_plv3);

	always_comb begin
		mapped_miss = 1'b0;
		paddr       = vaddr;
		mat         = cfg_datm;
		if (!cfg_direct) begin
			if (w0_hit) begin
				paddr = {w0_pseg, vaddr[`EXE_XLEN-`EXE_SEG_W-1:0]};
				mat   = w0_mat;
			end else if (w1_hit) begin
				paddr = {w1_pseg, vaddr[`EXE_XLEN-`EXE_SEG_W-1:0]};
				mat   = w1_mat;
			end else begin
				// no page table here, so refill
				mapped_miss = 1'b1;
			end
		end
	end

	assign uncache = (mat != `EXE_MAT_CC);

endmodule

/* source/exe_alu.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module exe_alu (
	input  exe_pkg::alu_func_e alu_func,
	input  logic [`EXE_XLEN-1:0] src1,
	input  logic [`EXE_XLEN-1:0] src2,
	output logic [`EXE_XLEN-1:0] result
);

	logic [4:0] shamt;
	logic slt_bit;
	logic sltu_bit;

	assign shamt    = src2[4:0];
	assign slt_bit  = ($signed(src1) < $signed(src2));
	assign sltu_bit = (src1 < src2);

	always_comb begin
		case (alu_func)
			exe_pkg::ALU_ADD:  result = src1 + src2;
			exe_pkg::ALU_SUB:  result = src1 - src2;
			exe_pkg::ALU_SLT:  result = {{(`EXE_XLEN-1){1'b0}}, slt_bit};
			exe_pkg::ALU_SLTU: result = {{(`EXE_XLEN-1){1'b0}}, sltu_bit};
			exe_pkg::ALU_AND:  result = src1 & src2;
			exe_pkg::ALU_OR:   result = src1 | src2;
			exe_pkg::ALU_NOR:  result = ~(src1 | src2);
			exe_pkg::ALU_XOR:  result = src1 ^ src2;
			exe_pkg::ALU_SLL:  result = src1 << shamt;
			exe_pkg::ALU_SRL:  result = src1 >> shamt;
			exe_pkg::ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);
			// upper immediate already built by decode
			exe_pkg::ALU_LUI:  result = src2;
			default:           result = '0;
		endcase
	end

endmodule

/* source/exe_issue_decode.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module exe_issue_decode (
	input  logic clk,
	input  logic reset,
	input  logic flush,
	input  logic in_valid,
	input  exe_pkg::op_kind_e in_kind,
	input  exe_pkg::exe_op_u in_op,
	input  logic in_src2_is_imm,
	input  logic in_gr_we,
	input  logic [`EXE_REG_AW-1:0] in_dest,
	input  logic [`EXE_XLEN-1:0] in_imm,
	input  logic [`EXE_XLEN-1:0] in_rj,
	input  logic [`EXE_XLEN-1:0] in_rkd,
	input  logic ready_go,
	input  logic mem_allowin,
	output logic exe_allowin,
	output logic stage_valid,
	output exe_pkg::alu_func_e alu_func,
	output logic [`EXE_XLEN-1:0] src1,
	output logic [`EXE_XLEN-1:0] src2,
	output logic is_mem,
	output logic is_store,
	output logic is_load,
	output logic [`EXE_SIZE_BITS-1:0] mem_size,
	output logic mem_unsigned,
	output logic gr_we,
	output logic [`EXE_REG_AW-1:0] dest,
	output logic [`EXE_XLEN-1:0] store_data
);

	exe_pkg::op_kind_e kind_r;
	exe_pkg::exe_op_u op_r;
	logic src2_is_imm_r;
	logic [`EXE_XLEN-1:0] imm_r;
	logic [`EXE_XLEN-1:0] rj_r;
	logic [`EXE_XLEN-1:0] rkd_r;

	assign exe_allowin = !stage_valid || (ready_go && mem_allowin);

	// flush wins over a new item
	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else if (flush) begin
			stage_valid <= 1'b0;
		end else if (exe_allowin) begin
			stage_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && exe_allowin) begin
			kind_r        <= in_kind;
			op_r          <= in_op;
			src2_is_imm_r <= in_src2_is_imm;
			gr_we         <= in_gr_we;
			dest          <= in_dest;
			imm_r         <= in_imm;
			rj_r          <= in_rj;
			rkd_r         <= in_rkd;
		end
	end

	assign is_mem = (kind_r == exe_pkg::OP_MEM);

	// memory ops reuse the adder for rj + imm
	assign alu_func = is_mem ? exe_pkg::ALU_ADD : op_r.alu;
	assign src1     = rj_r;
	assign src2     = (is_mem || src2_is_imm_r) ? imm_r : rkd_r;

	assign is_store     = is_mem && op_r.mem.is_store;
	assign is_load      = is_mem && !op_r.mem.is_store;
	assign mem_size     = op_r.mem.size;
	assign mem_unsigned = op_r.mem.is_unsigned;
	assign store_data   = rkd_r;

endmodule

/* source/exe_mem_request.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module exe_mem_request (
	input  logic stage_valid,
	input  logic flush,
	input  logic mem_allowin,
	input  logic is_mem,
	input  logic is_store,
	input  logic is_load,
	input  logic [`EXE_SIZE_BITS-1:0] mem_size,
	input  logic [`EXE_XLEN-1:0] vaddr,
	input  logic [`EXE_XLEN-1:0] paddr,
	input  logic mapped_miss,
	input  logic uncache,
	input  logic [`EXE_XLEN-1:0] store_data,
	input  logic data_addr_ok,
	output logic data_req,
	output logic data_wr,
	output logic [`EXE_SIZE_BITS-1:0] data_size,
	output logic [3:0] data_wstrb,
	output logic [`EXE_XLEN-1:0] data_addr,
	output logic [`EXE_XLEN-1:0] data_wdata,
	output logic data_uncache,
	output logic ready_go,
	output logic ex,
	output logic [`EXE_ECODE_W-1:0] ecode
);

	logic mem_access;
	logic align_err;
	logic wr_ok;
	logic [3:0] strb;

	assign mem_access = stage_valid && (is_load || is_store);

	assign align_err = ((mem_size == `EXE_SIZE_H) && vaddr[0]) ||
		((mem_size == `EXE_SIZE_W) && (vaddr[1:0] != 2'b00));

	assign ex    = mem_access && (align_err || mapped_miss);
	// misaligned reported ahead of the miss
	assign ecode = align_err ? `EXE_ECODE_ALE : `EXE_ECODE_TLBR;

	assign data_req = mem_access && !ex && mem_allowin && !flush;
	assign wr_ok    = stage_valid && is_store && !ex;
	assign data_wr  = wr_ok;

	always_comb begin
		case (mem_size)
			`EXE_SIZE_B: strb = 4'b0001 << vaddr[1:0];
			`EXE_SIZE_H: strb = vaddr[1] ? 4'b1100 : 4'b0011;
			`EXE_SIZE_W: strb = 4'b1111;
			default:     strb = 4'b0000;
		endcase
	end

	assign data_wstrb = wr_ok ? strb : 4'b0000;

	// narrow stores replicated across the word
	always_comb begin
		case (mem_size)
			`EXE_SIZE_B: data_wdata = {4{store_data[7:0]}};
			`EXE_SIZE_H: data_wdata = {2{store_data[15:0]}};
			default:     data_wdata = store_data;
		endcase
	end

	assign data_size    = mem_size;
	assign data_addr    = paddr;
	assign data_uncache = uncache;

	// excepted memory ops leave without a request
	assign ready_go = !(stage_valid && is_mem) || ex || (data_req && data_addr_ok);

endmodule

/* source/exe_params.svh */
`ifndef EXE_PARAMS_SVH
`define EXE_PARAMS_SVH

// datapath and register file
`define EXE_XLEN 32
`define EXE_REG_AW 5

// exception codes
`define EXE_ECODE_W 6
`define EXE_ECODE_ALE 6'd9
`define EXE_ECODE_TLBR 6'h3F

// request sizes on the data bus
`define EXE_SIZE_BITS 2
`define EXE_SIZE_B 2'd0
`define EXE_SIZE_H 2'd1
`define EXE_SIZE_W 2'd2

// privilege levels checked by the windows
`define EXE_PLV_W 2
`define EXE_PLV0 2'd0
`define EXE_PLV3 2'd3

// memory access type, only CC is cached
`define EXE_MAT_W 2
`define EXE_MAT_CC 2'd1

// top address bits that select a window
`define EXE_SEG_W 3

`endif

/* source/exe_pkg.sv */
`include "exe_params.svh"

package exe_pkg;

	typedef enum logic {
		OP_ALU = 1'b0,
		OP_MEM = 1'b1
	} op_kind_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLT  = 4'd2,
		ALU_SLTU = 4'd3,
		ALU_AND  = 4'd4,
		ALU_OR   = 4'd5,
		ALU_NOR  = 4'd6,
		ALU_XOR  = 4'd7,
		ALU_SLL  = 4'd8,
		ALU_SRL  = 4'd9,
		ALU_SRA  = 4'd10,
		ALU_LUI  = 4'd11
	} alu_func_e;

	// load/store control bits
	typedef struct packed {
		logic is_store;
		logic [`EXE_SIZE_BITS-1:0] size;
		logic is_unsigned;
	} mem_ctrl_t;

	// one op word, read by kind
	typedef union packed {
		alu_func_e alu;
		mem_ctrl_t mem;
	} exe_op_u;

endpackage

/* source/exe_top.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module exe_top (
	input  logic clk,
	input  logic reset,
	input  logic flush,
	input  logic in_valid,
	input  exe_pkg::op_kind_e in_kind,
	input  exe_pkg::exe_op_u in_op,
	input  logic in_src2_is_imm,
	input  logic in_gr_we,
	input  logic [`EXE_REG_AW-1:0] in_dest,
	input  logic [`EXE_XLEN-1:0] in_imm,
	input  logic [`EXE_XLEN-1:0] in_rj,
	input  logic [`EXE_XLEN-1:0] in_rkd,
	output logic exe_allowin,
	input  logic mem_allowin,
	output logic out_valid,
	output logic [`EXE_XLEN-1:0] out_result,
	output logic out_gr_we,
	output logic [`EXE_REG_AW-1:0] out_dest,
	output logic out_is_load,
	output logic [`EXE_SIZE_BITS-1:0] out_size,
	output logic out_unsigned,
	output logic out_ex,
	output logic [`EXE_ECODE_W-1:0] out_ecode,
	output logic [`EXE_XLEN-1:0] out_badv,
	output logic data_req,
	output logic data_wr,
	output logic [`EXE_SIZE_BITS-1:0] data_size,
	output logic [3:0] data_wstrb,
	output logic [`EXE_XLEN-1:0] data_addr,
	output logic [`EXE_XLEN-1:0] data_wdata,
	output logic data_uncache,
	input  logic data_addr_ok,
	input  logic [`EXE_PLV_W-1:0] cfg_plv,
	input  logic cfg_direct,
	input  logic [`EXE_MAT_W-1:0] cfg_datm,
	input  logic [`EXE_SEG_W-1:0] w0_vseg,
	input  logic [`EXE_SEG_W-1:0] w0_pseg,
	input  logic w0_plv0,
	input  logic w0_plv3,
	input  logic [`EXE_MAT_W-1:0] w0_mat,
	input  logic [`EXE_SEG_W-1:0] w1_vseg,
	input  logic [`EXE_SEG_W-1:0] w1_pseg,
	input  logic w1_plv0,
	input  logic w1_plv3,
	input  logic [`EXE_MAT_W-1:0] w1_mat
);

	logic stage_valid;
	logic ready_go;
	exe_pkg::alu_func_e alu_func;
	logic [`EXE_XLEN-1:0] src1;
	logic [`EXE_XLEN-1:0] src2;
	logic is_mem;
	logic is_store;
	logic is_load;
	logic [`EXE_SIZE_BITS-1:0] mem_size;
	logic mem_unsigned;
	logic gr_we;
	logic [`EXE_REG_AW-1:0] dest;
	logic [`EXE_XLEN-1:0] store_data;
	logic [`EXE_XLEN-1:0] alu_result;
	logic [`EXE_XLEN-1:0] paddr;
	logic mapped_miss;
	logic uncache;
	logic ex;
	logic [`EXE_ECODE_W-1:0] ecode;

	exe_issue_decode i_decode (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.in_valid(in_valid),
		.in_kind(in_kind),
		.in_op(in_op),
		.in_src2_is_imm(in_src2_is_imm),
		.in_gr_we(in_gr_we),
		.in_dest(in_dest),
		.in_imm(in_imm),
		.in_rj(in_rj),
		.in_rkd(in_rkd),
		.ready_go(ready_go),
		.mem_allowin(mem_allowin),
		.exe_allowin(exe_allowin),
		.stage_valid(stage_valid),
		.alu_func(alu_func),
		.src1(src1),
		.src2(src2),
		.is_mem(is_mem),
		.is_store(is_store),
		.is_load(is_load),
		.mem_size(mem_size),
		.mem_unsigned(mem_unsigned),
		.gr_we(gr_we),
		.dest(dest),
		.store_data(store_data)
	);

	exe_alu i_alu (
		.alu_func(alu_func),
		.src1(src1),
		.src2(src2),
		.result(alu_result)
	);

	// alu result doubles as the virtual address
	exe_addr_translate i_translate (
		.vaddr(alu_result),
		.cfg_plv(cfg_plv),
		.cfg_direct(cfg_direct),
		.cfg_datm(cfg_datm),
		.w0_vseg(w0_vseg),
		.w0_pseg(w0_pseg),
		.w0_plv0(w0_plv0),
		.w0_plv3(w0_plv3),
		.w0_mat(w0_mat),
		.w1_vseg(w1_vseg),
		.w1_pseg(w1_pseg),
		.w1_plv0(w1_plv0),
		.w1_plv3(w1_plv3),
		.w1_mat(w1_mat),
		.paddr(paddr),
		.mapped_miss(mapped_miss),
		.uncache(uncache)
	);

	exe_mem_request i_mem_req (
		.stage_valid(stage_valid),
		.flush(flush),
		.mem_allowin(mem_allowin),
		.is_mem(is_mem),
		.is_store(is_store),
		.is_load(is_load),
		.mem_size(mem_size),
		.vaddr(alu_result),
		.paddr(paddr),
		.mapped_miss(mapped_miss),
		.uncache(uncache),
		.store_data(store_data),
		.data_addr_ok(data_addr_ok),
		.data_req(data_req),
		.data_wr(data_wr),
		.data_size(data_size),
		.data_wstrb(data_wstrb),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_uncache(data_uncache),
		.ready_go(ready_go),
		.ex(ex),
		.ecode(ecode)
	);

	assign out_valid    = stage_valid && ready_go;
	assign out_result   = alu_result;
	assign out_badv     = alu_result;
	assign out_gr_we    = gr_we;
	assign out_dest     = dest;
	assign out_is_load  = is_load;
	assign out_size     = mem_size;
	assign out_unsigned = mem_unsigned;
	assign out_ex       = ex;
	assign out_ecode    = ecode;

endmodule

/* tests/exe_tb.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module exe_tb;

	localparam int NUM_BATCHES = 8;
	localparam int BATCH_ITEMS = 50;
	// 400 items at a few cycles each, with wide margin for stalls
	localparam int MAX_CYCLES = 10000;

	typedef struct packed {
		logic is_mem;
		logic is_store;
		logic gr_we;
		logic [`EXE_REG_AW-1:0] dest;
		logic [`EXE_SIZE_BITS-1:0] size;
		logic uns;
		logic ex;
		logic [`EXE_ECODE_W-1:0] ecode;
		logic [`EXE_XLEN-1:0] result;
		logic [`EXE_XLEN-1:0] paddr;
		logic [3:0] wstrb;
		logic [`EXE_XLEN-1:0] wdata;
		logic uncache;
	} exp_item_t;

	logic clk, reset, flush, in_valid, in_src2_is_imm, in_gr_we;
	logic exe_allowin, mem_allowin, out_valid, out_gr_we, out_is_load, out_unsigned, out_ex;
	logic data_req, data_wr, data_uncache, data_addr_ok;
	logic cfg_direct, w0_plv0, w0_plv3, w1_plv0, w1_plv3;
	logic [`EXE_XLEN-1:0] in_imm, in_rj, in_rkd, out_result, out_badv, data_addr, data_wdata;
	logic [`EXE_REG_AW-1:0] in_dest, out_dest;
	logic [`EXE_SIZE_BITS-1:0] out_size, data_size;
	logic [`EXE_ECODE_W-1:0] out_ecode;
	logic [3:0] data_wstrb;
	logic [`EXE_PLV_W-1:0] cfg_plv;
	logic [`EXE_MAT_W-1:0] cfg_datm, w0_mat, w1_mat;
	logic [`EXE_SEG_W-1:0] w0_vseg, w0_pseg, w1_vseg, w1_pseg;
	exe_pkg::op_kind_e in_kind;
	exe_pkg::exe_op_u in_op;

	exp_item_t exp_q[$];
	exp_item_t out_exp;
	exp_item_t req_exp;
	int error_count = 0;
	int check_count = 0;
	int cycle_count = 0;

	exe_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
			error_count++;
		end
	endtask

	function automatic logic window_ok(input logic [2:0] seg, input logic [2:0] vseg,
		input logic p0, input logic p3);
		return (seg == vseg) && ((cfg_plv == 2'd0 && p0) || (cfg_plv == 2'd3 && p3));
	endfunction

	function automatic exp_item_t exe_ref(input logic mem_op, input logic [3:0] op,
		input logic src2_imm, input logic gr_we, input logic [`EXE_REG_AW-1:0] dest,
		input logic [31:0] imm, input logic [31:0] rj, input logic [31:0] rkd);
		exp_item_t e;
		logic [31:0] b;
		logic [4:0] sh;
		logic hit0;
		logic hit1;
		logic align;
		logic [1:0] mat;
		e = '0;
		e.is_mem = mem_op;
		e.gr_we = gr_we;
		e.dest = dest;
		b = (mem_op || src2_imm) ? imm : rkd;
		sh = b[4:0];
		case (mem_op ? 4'd0 : op)
			4'd0: e.result = rj + b;
			4'd1: e.result = rj - b;
			4'd2: e.result = (rj[31] != b[31]) ? rj[31] : (rj < b);
			4'd3: e.result = (rj < b);
			4'd4: e.result = rj & b;
			4'd5: e.result = rj | b;
			4'd6: e.result = ~(rj | b);
			4'd7: e.result = rj ^ b;
			4'd8: e.result = rj << sh;
			4'd9: e.result = rj >> sh;
			4'd10: e.result = (rj >> sh) | (rj[31] ? ~(32'hffffffff >> sh) : 32'h0);
			default: e.result = b;
		endcase
		if (mem_op) begin
			e.is_store = op[3];
			e.size = op[2:1];
			e.uns = op[0];
			hit0 = !cfg_direct && window_ok(e.result[31:29], w0_vseg, w0_plv0, w0_plv3);
			hit1 = !cfg_direct && window_ok(e.result[31:29], w1_vseg, w1_plv0, w1_plv3);
			e.paddr = e.result;
			mat = cfg_datm;
			if (hit0) begin
				e.paddr[31:29] = w0_pseg;
				mat = w0_mat;
			end else if (hit1) begin
				e.paddr[31:29] = w1_pseg;
				mat = w1_mat;
			end
			align = (e.size == 2'd1 && e.result[0]) || (e.size == 2'd2 && e.result[1:0] != 0);
			e.ex = align || (!cfg_direct && !hit0 && !hit1);
			e.ecode = align ? `EXE_ECODE_ALE : `EXE_ECODE_TLBR;
			e.uncache = (mat != `EXE_MAT_CC);
			case (e.size)
				2'd0: e.wstrb = 4'b0001 << e.result[1:0];
				2'd1: e.wstrb = e.result[1] ? 4'b1100 : 4'b0011;
				default: e.wstrb = 4'b1111;
			endcase
			e.wdata = (e.size == 2'd0) ? {4{rkd[7:0]}} :
				(e.size == 2'd1) ? {2{rkd[15:0]}} : rkd;
			if (!e.is_store || e.ex)
				e.wstrb = 4'b0000;
		end
		return e;
	endfunction

	task automatic set_config();
		cfg_direct = ($urandom_range(0, 3) == 0);
		cfg_plv = ($urandom_range(0, 4) == 0) ? 2'd1 : ($urandom_range(0, 1) ? 2'd3 : 2'd0);
		cfg_datm = $urandom_range(0, 3);
		w0_vseg = $urandom_range(0, 7);
		w0_pseg = $urandom_range(0, 7);
		w0_plv0 = $urandom_range(0, 1);
		w0_plv3 = $urandom_range(0, 1);
		w0_mat = $urandom_range(0, 3);
		w1_vseg = $urandom_range(0, 7);
		w1_pseg = $urandom_range(0, 7);
		w1_plv0 = $urandom_range(0, 1);
		w1_plv3 = $urandom_range(0, 1);
		w1_mat = $urandom_range(0, 3);
	endtask

	task automatic present_item();
		logic [3:0] op;
		in_kind = $urandom_range(0, 1) ? exe_pkg::OP_MEM : exe_pkg::OP_ALU;
		in_gr_we = $urandom_range(0, 1);
		in_dest = $urandom_range(0, 31);
		in_src2_is_imm = $urandom_range(0, 1);
		in_rj = $urandom();
		in_rkd = $urandom();
		in_imm = $urandom();
		op = $urandom_range(0, 11);
		if (in_kind == exe_pkg::OP_MEM) begin
			op[3] = $urandom_range(0, 1);
			op[2:1] = $urandom_range(0, 2);
			op[0] = $urandom_range(0, 1);
			// bias addresses into the window segments
			case ($urandom_range(0, 2))
				0: in_rj[31:29] = w0_vseg;
				1: in_rj[31:29] = w1_vseg;
				default: in_rj[31:29] = $urandom_range(0, 7);
			endcase
			in_rj[1:0] = 2'b00;
			in_imm = $urandom_range(0, 255);
			if ($urandom_range(0, 3) != 0)
				in_imm[1:0] = 2'b00;
		end
		in_op = op;
		in_valid = 1'b1;
	endtask

	// memory stage and data bus, flush only while stalled
	always @(negedge clk) begin
		if (reset !== 1'b0) begin
			flush = 1'b0;
			mem_allowin = 1'b1;
			data_addr_ok = 1'b0;
		end else begin
			flush = ($urandom_range(0, 39) == 0);
			mem_allowin = flush ? 1'b0 : ($urandom_range(0, 3) != 0);
			data_addr_ok = ($urandom_range(0, 2) != 0);
		end
	end

	always @(posedge clk) begin
		if (reset || flush)
			exp_q.delete();
		else if (in_valid && exe_allowin)
			exp_q.push_back(exe_ref(in_kind == exe_pkg::OP_MEM, in_op, in_src2_is_imm,
				in_gr_we, in_dest, in_imm, in_rj, in_rkd));
	end

	// pop waits for the falling edge so the request check sees the same head
	always @(posedge clk) begin
		if (!reset && out_valid && mem_allowin) begin
			if (exp_q.size() == 0) begin
				$display("output transfer at %0t with no item pending", $time);
				error_count++;
			end else begin
				out_exp = exp_q[0];
				check_value("out_result", out_result, out_exp.result);
				check_value("out_gr_we", out_gr_we, out_exp.gr_we);
				check_value("out_dest", out_dest, out_exp.dest);
				check_value("out_is_load", out_is_load, out_exp.is_mem && !out_exp.is_store);
				check_value("out_ex", out_ex, out_exp.ex);
				if (out_exp.is_mem) begin
					check_value("out_size", out_size, out_exp.size);
					check_value("out_unsigned", out_unsigned, out_exp.uns);
				end
				if (out_exp.ex) begin
					check_value("out_ecode", out_ecode, out_exp.ecode);
					check_value("out_badv", out_badv, out_exp.result);
				end
				@(negedge clk);
				void'(exp_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		if (!reset && data_req && data_addr_ok) begin
			if (exp_q.size() == 0 || !exp_q[0].is_mem || exp_q[0].ex) begin
				$display("data request at %0t for an item that must not issue one", $time);
				error_count++;
			end else begin
				req_exp = exp_q[0];
				check_value("data_wr", data_wr, req_exp.is_store);
				check_value("data_size", data_size, req_exp.size);
				check_value("data_addr", data_addr, req_exp.paddr);
				check_value("data_uncache", data_uncache, req_exp.uncache);
				check_value("data_wstrb", data_wstrb, req_exp.wstrb);
				if (req_exp.is_store)
					check_value("data_wdata", data_wdata, req_exp.wdata);
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h736e3282));
		reset = 1'b1;
		flush = 1'b0;
		mem_allowin = 1'b1;
		data_addr_ok = 1'b0;
		in_valid = 1'b0;
		in_kind = exe_pkg::OP_ALU;
		in_op = '0;
		in_src2_is_imm = 1'b0;
		in_gr_we = 1'b0;
		in_dest = '0;
		in_imm = '0;
		in_rj = '0;
		in_rkd = '0;
		set_config();
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		check_value("out_valid after reset", out_valid, 1'b0);
		check_value("data_req after reset", data_req, 1'b0);
		check_value("data_wr after reset", data_wr, 1'b0);
		check_value("out_ex after reset", out_ex, 1'b0);
		check_value("data_wstrb after reset", data_wstrb, 4'b0000);
		check_value("exe_allowin after reset", exe_allowin, 1'b1);
		for (int batch = 0; batch < NUM_BATCHES; batch++) begin
			while (exp_q.size() != 0)
				@(negedge clk);
			set_config();
			repeat (BATCH_ITEMS) begin
				present_item();
				@(posedge clk);
				while (!(exe_allowin && !flush))
					@(posedge clk);
				@(negedge clk);
				in_valid = 1'b0;
				if ($urandom_range(0, 3) == 0)
					@(negedge clk);
			end
		end
		while (exp_q.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		$display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
			i_dut.i_assert.fail_count);
		if (error_count == 0 && i_dut.i_assert.fail_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* tests/exe_tb_assert.sv */
`timescale 1ns/1ps
`include "exe_params.svh"

module exe_tb_assert (
	input logic clk,
	input logic reset,
	input logic stage_valid,
	input logic mem_allowin,
	input logic out_valid,
	input logic [`EXE_XLEN-1:0] out_result,
	input logic data_req,
	input logic data_wr,
	input logic [3:0] data_wstrb,
	input logic ex
);

	int fail_count = 0;

	req_no_ex: assert property (@(posedge clk) disable iff (reset) data_req |-> !ex)
		else begin
			fail_count++;
			$error("data request raised together with an exception");
		end

	strb_needs_wr: assert property (@(posedge clk) disable iff (reset)
		!data_wr |-> (data_wstrb == 4'b0000))
		else begin
			fail_count++;
			$error("byte strobes active without a write");
		end

	// held result under back-pressure
	result_held: assert property (@(posedge clk) disable iff (reset)
		(out_valid && !mem_allowin) |=> $stable(out_result))
		else begin
			fail_count++;
			$error("result changed while the memory stage stalled");
		end

	req_needs_valid: assert property (@(posedge clk) disable iff (reset)
		data_req |-> stage_valid)
		else begin
			fail_count++;
			$error("data request from an empty stage");
		end

endmodule

bind exe_top exe_tb_assert i_assert (
	.clk(clk),
	.reset(reset),
	.stage_valid(stage_valid),
	.mem_allowin(mem_allowin),
	.out_valid(out_valid),
	.out_result(out_result),
	.data_req(data_req),
	.data_wr(data_wr),
	.data_wstrb(data_wstrb),
	.ex(ex)
);
